// ==== ex_pkg.sv ====
// Execute stage shared types
package ex_pkg;

  ////////////////////
  // Operation codes
  ////////////////////

  // One code per operation, NOP first
  typedef enum logic [4:0] {
    NOP   = 5'd0,
    ADD   = 5'd1,
    SUB   = 5'd2,
    AND   = 5'd3,
    OR    = 5'd4,
    XOR   = 5'd5,
    SLL   = 5'd6,
    SRL   = 5'd7,
    SRA   = 5'd8,
    SLT   = 5'd9,
    SLTU  = 5'd10,
    MUL   = 5'd11,
    MULH  = 5'd12,
    MULHU = 5'd13,
    DIV   = 5'd14,
    DIVU  = 5'd15,
    REM   = 5'd16,
    REMU  = 5'd17
  } ex_op_e;

  // Decoded instruction handed over by ID
  typedef struct packed {
    logic       bubble;  // high when no valid operation
    ex_op_e     op;
    logic [4:0] rd;      // destination tag, passed through
  } ex_insn_t;

  ////////////////////
  // Class helpers
  ////////////////////

  // Operation handled by the multiply/divide unit
  function automatic logic is_muldiv(input ex_op_e op);
    case (op)
      MUL, MULH, MULHU, DIV, DIVU, REM, REMU: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Multiply flavours
  function automatic logic is_mul(input ex_op_e op);
    return (op == MUL) || (op == MULH) || (op == MULHU);
  endfunction

  // Remainder flavours
  function automatic logic is_rem(input ex_op_e op);
    return (op == REM) || (op == REMU);
  endfunction

  // Operands taken as two's complement
  function automatic logic signed_operands(input ex_op_e op);
    return (op == MULH) || (op == DIV) || (op == REM);
  endfunction

endpackage

// ==== ex_alu.sv ====
// Single-cycle integer ALU
`timescale 1ns/10ps

module ex_alu
  import ex_pkg::*;
#(
  parameter int unsigned XLEN = 32
)
(
  input  logic            clk_i,
  input  logic            rst_ni,

  // Pipeline control
  input  logic            stall_i,
  input  logic            flush_i,

  // Operation and operands
  input  ex_insn_t        insn_i,
  input  logic [XLEN-1:0] opa_i,
  input  logic [XLEN-1:0] opb_i,

  // Registered result
  output logic            bubble_o,
  output logic [XLEN-1:0] result_o
);

  // Shift amount width
  localparam int unsigned SHW = $clog2(XLEN);

  ////////////////////
  // Variables
  ////////////////////

  logic [SHW-1:0]  shamt;
  logic [XLEN-1:0] alu_r;
  logic            alu_valid;

  ////////////////////
  // Operation decode
  ////////////////////

  // Only valid non-MUL/DIV work belongs here
  assign alu_valid = ~insn_i.bubble &
                     ~is_muldiv(insn_i.op) &
                     (insn_i.op != NOP);

  // Low bits of opB only
  assign shamt = opb_i[SHW-1:0];

  ////////////////////
  // Datapath
  ////////////////////

  always_comb
  begin
    alu_r = '0;
    case (insn_i.op)
      ADD:  alu_r = opa_i + opb_i;
      SUB:  alu_r = opa_i - opb_i;
      AND:  alu_r = opa_i & opb_i;
      OR:   alu_r = opa_i | opb_i;
      XOR:  alu_r = opa_i ^ opb_i;
      SLL:  alu_r = opa_i << shamt;
      SRL:  alu_r = opa_i >> shamt;
      // Arithmetic shift keeps the sign
      SRA:  alu_r = $unsigned($signed(opa_i) >>> shamt);
      // Compares give 0 or 1
      SLT:  alu_r = {{(XLEN-1){1'b0}}, $signed(opa_i) < $signed(opb_i)};
      SLTU: alu_r = {{(XLEN-1){1'b0}}, opa_i < opb_i};
      default: alu_r = '0;
    endcase
  end

  ////////////////////
  // Output register
  ////////////////////

  // Flush wins over stall
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      bubble_o <= 1'b1;
      result_o <= '0;
    end
    else if (flush_i)
    begin
      bubble_o <= 1'b1;
    end
    else if (!stall_i)
    begin
      bubble_o <= ~alu_valid;
      // Last result kept across bubbles for bypass
      if (alu_valid)
      begin
        result_o <= alu_r;
      end
    end
  end

endmodule

// ==== ex_muldiv.sv ====
// Iterative multiply/divide unit
`timescale 1ns/10ps

module ex_muldiv
  import ex_pkg::*;
#(
  parameter int unsigned XLEN = 32
)
(
  input  logic            clk_i,
  input  logic            rst_ni,

  // Pipeline control
  input  logic            stall_i,
  input  logic            flush_i,

  // Operation and operands
  input  ex_insn_t        insn_i,
  input  logic [XLEN-1:0] opa_i,
  input  logic [XLEN-1:0] opb_i,

  // Status and result
  output logic            busy_o,
  output logic            bubble_o,
  output logic [XLEN-1:0] result_o
);

  // Step counter runs 0..XLEN
  localparam int unsigned CW = $clog2(XLEN + 1);

  ////////////////////
  // Variables
  ////////////////////

  logic              start;
  logic              last_step;
  logic [CW-1:0]     cnt_q;
  ex_op_e            op_q;
  logic              neg_q;      // final sign flip
  logic [XLEN-1:0]   operand_q;  // multiplicand or divisor
  logic [2*XLEN-1:0] acc_q;      // {hi, lo}

  logic              sa, sb;
  logic [XLEN-1:0]   mag_a, mag_b;
  logic [XLEN:0]     add_sum, rem_sh, sub_diff;
  logic [2*XLEN-1:0] step_acc, prod;
  logic [XLEN-1:0]   quot, rem, fin_r;

  assign start     = ~insn_i.bubble & is_muldiv(insn_i.op);
  assign last_step = (cnt_q == CW'(XLEN));

  ////////////////////
  // Operand setup
  ////////////////////

  // Magnitudes and sign flags
  assign sa    = signed_operands(insn_i.op) & opa_i[XLEN-1];
  assign sb    = signed_operands(insn_i.op) & opb_i[XLEN-1];
  assign mag_a = sa ? -opa_i : opa_i;
  assign mag_b = sb ? -opb_i : opb_i;

  ////////////////////
  // One iteration
  ////////////////////

  // Shift-add step with carry into the top bit
  assign add_sum  = {1'b0, acc_q[2*XLEN-1:XLEN]} + {1'b0, operand_q};
  // Restoring subtract on shifted remainder
  assign rem_sh   = acc_q[2*XLEN-1:XLEN-1];
  assign sub_diff = rem_sh - {1'b0, operand_q};

  always_comb
  begin
    if (is_mul(op_q))
      step_acc = acc_q[0] ? {add_sum, acc_q[XLEN-1:1]} : {1'b0, acc_q[2*XLEN-1:1]};
    else if (sub_diff[XLEN])
      step_acc = {acc_q[2*XLEN-2:0], 1'b0};
    else
      step_acc = {sub_diff[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};
  end

  ////////////////////
  // Sign correction
  ////////////////////

  // Zero divisor and overflow fall out of the magnitudes
  assign prod = neg_q ? -acc_q : acc_q;
  assign quot = neg_q ? -acc_q[XLEN-1:0] : acc_q[XLEN-1:0];
  assign rem  = neg_q ? -acc_q[2*XLEN-1:XLEN] : acc_q[2*XLEN-1:XLEN];

  always_comb
  begin
    if (op_q == MUL)
      fin_r = prod[XLEN-1:0];
    else if (is_mul(op_q))
      fin_r = prod[2*XLEN-1:XLEN];
    else if (is_rem(op_q))
      fin_r = rem;
    else
      fin_r = quot;
  end

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      busy_o   <= 1'b0;
      bubble_o <= 1'b1;
      cnt_q    <= '0;
    end
    else if (flush_i)
    begin
      // Abort in-flight work
      busy_o   <= 1'b0;
      bubble_o <= 1'b1;
    end
    else if (!stall_i)
    begin
      if (busy_o)
      begin
        if (last_step)
        begin
          busy_o   <= 1'b0;
          bubble_o <= 1'b0;
        end
        else
          cnt_q <= cnt_q + 1'b1;
      end
      else
      begin
        // Any accepting edge retires the old result
        bubble_o <= 1'b1;
        busy_o   <= start;
        cnt_q    <= '0;
      end
    end
  end

  // Datapath registers
  always_ff @(posedge clk_i)
  begin
    if (!stall_i && !flush_i)
    begin
      if (busy_o)
      begin
        if (last_step)
          result_o <= fin_r;
        else
          acc_q <= step_acc;
      end
      else if (start)
      begin
        op_q  <= insn_i.op;
        // Remainder follows the dividend sign
        neg_q <= is_rem(insn_i.op) ? sa : (sa ^ sb) & (|opb_i);
        if (is_mul(insn_i.op))
        begin
          acc_q     <= {{XLEN{1'b0}}, mag_b};
          operand_q <= mag_a;
        end
        else
        begin
          acc_q     <= {{XLEN{1'b0}}, mag_a};
          operand_q <= mag_b;
        end
      end
    end
  end

endmodule

// ==== ex_stage.sv ====
// Integer execute stage
`timescale 1ns/10ps

module ex_stage
  import ex_pkg::*;
#(
  parameter int unsigned XLEN = 32
)
(
  input  logic            clk_i,
  input  logic            rst_ni,

  // Pipeline control
  input  logic            mem_stall_i,
  input  logic            flush_i,
  output logic            ex_stall_o,

  // From ID
  input  ex_insn_t        id_insn_i,
  input  logic [XLEN-1:0] id_opA_i,
  input  logic [XLEN-1:0] id_opB_i,
  input  logic            id_userf_opA_i,
  input  logic            id_userf_opB_i,
  input  logic            id_bypex_opA_i,
  input  logic            id_bypex_opB_i,

  // From register file
  input  logic [XLEN-1:0] rf_srcv1_i,
  input  logic [XLEN-1:0] rf_srcv2_i,

  // To MEM
  output ex_insn_t        ex_insn_o,
  output logic [XLEN-1:0] ex_r_o
);

  ////////////////////
  // Variables
  ////////////////////

  logic [XLEN-1:0] opa, opb;

  logic [XLEN-1:0] alu_r, md_r;
  logic            alu_bubble, md_bubble;
  logic            md_busy;

  ex_op_e          op_q;
  logic [4:0]      rd_q;

  ////////////////////
  // Operand bypass
  ////////////////////

  // Own result first, then RF, then ID value
  always_comb
  begin
    if (id_bypex_opA_i)
      opa = ex_r_o;
    else if (id_userf_opA_i)
      opa = rf_srcv1_i;
    else
      opa = id_opA_i;
  end

  always_comb
  begin
    if (id_bypex_opB_i)
      opb = ex_r_o;
    else if (id_userf_opB_i)
      opb = rf_srcv2_i;
    else
      opb = id_opB_i;
  end

  ////////////////////
  // Execution units
  ////////////////////

  // ALU holds on any stall
  ex_alu #(
    .XLEN     ( XLEN       )
  ) alu (
    .clk_i    ( clk_i      ),
    .rst_ni   ( rst_ni     ),
    .stall_i  ( ex_stall_o ),
    .flush_i  ( flush_i    ),
    .insn_i   ( id_insn_i  ),
    .opa_i    ( opa        ),
    .opb_i    ( opb        ),
    .bubble_o ( alu_bubble ),
    .result_o ( alu_r      )
  );

  // MUL/DIV pauses only on MEM stall
  // Its own busy level gates acceptance
  ex_muldiv #(
    .XLEN     ( XLEN        )
  ) muldiv (
    .clk_i    ( clk_i       ),
    .rst_ni   ( rst_ni      ),
    .stall_i  ( mem_stall_i ),
    .flush_i  ( flush_i     ),
    .insn_i   ( id_insn_i   ),
    .opa_i    ( opa         ),
    .opb_i    ( opb         ),
    .busy_o   ( md_busy     ),
    .bubble_o ( md_bubble   ),
    .result_o ( md_r        )
  );

  ////////////////////
  // Instruction copy
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      op_q <= NOP;
      rd_q <= '0;
    end
    else if (!ex_stall_o && !flush_i)
    begin
      op_q <= id_insn_i.op;
      rd_q <= id_insn_i.rd;
    end
  end

  ////////////////////
  // Combined output
  ////////////////////

  assign ex_stall_o = mem_stall_i | md_busy;

  assign ex_insn_o = '{bubble: alu_bubble & md_bubble, op: op_q, rd: rd_q};

  // MUL/DIV result while its bubble is low
  assign ex_r_o = md_bubble ? alu_r : md_r;

endmodule

// ==== ex_stage_props.sv ====
// Execute stage assertions
`timescale 1ns/10ps

module ex_stage_props
  import ex_pkg::*;
#(
  parameter int unsigned XLEN = 32
)
(
  input logic            clk_i,
  input logic            rst_ni,
  input logic            mem_stall_i,
  input logic            flush_i,
  input logic            ex_stall_i,
  input logic            md_busy_i,
  input ex_insn_t        ex_insn_i,
  input logic [XLEN-1:0] ex_r_i
);

  // Busy run length cleared by a pause or an abort
  logic [7:0] busy_run;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      busy_run <= '0;
    else if (md_busy_i && !mem_stall_i && !flush_i)
      busy_run <= busy_run + 8'd1;
    else
      busy_run <= '0;
  end

  // Stall must always resolve
  stall_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(ex_stall_i))
    else $error("ex_stall_o is unknown");

  // MEM back-pressure freezes the outputs
  hold_on_mem_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_stall_i && !flush_i |=> $stable(ex_r_i) && $stable(ex_insn_i))
    else $error("ex_r_o or ex_insn_o changed under mem_stall_i");

  // XLEN+1 steps plus a little slack
  busy_bounded: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_run <= 8'(XLEN + 3))
    else $error("MUL/DIV busy for too many cycles");

endmodule

// Attach to every execute stage
bind ex_stage ex_stage_props #(.XLEN(XLEN)) props0 (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .mem_stall_i ( mem_stall_i ),
  .flush_i     ( flush_i     ),
  .ex_stall_i  ( ex_stall_o  ),
  .md_busy_i   ( md_busy     ),
  .ex_insn_i   ( ex_insn_o   ),
  .ex_r_i      ( ex_r_o      )
);

// ==== tb_ex_stage.sv ====
// Execute stage testbench
`timescale 1ns/10ps

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int unsigned XLEN    = 32;
  localparam int unsigned SHW     = $clog2(XLEN);
  localparam int          NUM_OPS = 400;
  // Up to 40 cycles per operation plus margin
  localparam int          MAX_CYCLES = NUM_OPS * 40 + 4000;

  typedef logic [XLEN-1:0] word_t;

  // One expected retirement
  typedef struct packed {
    ex_insn_t insn;
    word_t    r;
  } exp_t;

  ////////////////////
  // DUT signals
  ////////////////////

  logic     clk = 1'b0;
  logic     rst_n, mem_stall, flush;
  ex_insn_t id_insn, ex_insn;
  word_t    id_opa, id_opb, rf_v1, rf_v2, ex_r;
  logic     userf_a, userf_b, byp_a, byp_b, ex_stall;

  exp_t     exp_q[$];
  int       cycles = 0;

  // 10 ns period
  always #5 clk = ~clk;

  ex_stage #(
    .XLEN           ( XLEN      )
  ) dut0 (
    .clk_i          ( clk       ),
    .rst_ni         ( rst_n     ),
    .mem_stall_i    ( mem_stall ),
    .flush_i        ( flush     ),
    .ex_stall_o     ( ex_stall  ),
    .id_insn_i      ( id_insn   ),
    .id_opA_i       ( id_opa    ),
    .id_opB_i       ( id_opb    ),
    .id_userf_opA_i ( userf_a   ),
    .id_userf_opB_i ( userf_b   ),
    .id_bypex_opA_i ( byp_a     ),
    .id_bypex_opB_i ( byp_b     ),
    .rf_srcv1_i     ( rf_v1     ),
    .rf_srcv2_i     ( rf_v2     ),
    .ex_insn_o      ( ex_insn   ),
    .ex_r_o         ( ex_r      )
  );

  ////////////////////
  // Reference model
  ////////////////////

  // RISC-V results including divide by zero and overflow
  function automatic word_t ref_exec(input ex_op_e op, input word_t a, input word_t b);
    logic signed [2*XLEN-1:0] sprod;
    logic [2*XLEN-1:0]        uprod;
    word_t                    min_int;
    min_int = {1'b1, {(XLEN-1){1'b0}}};
    sprod   = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
    uprod   = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    case (op)
      ADD:   return a + b;
      SUB:   return a - b;
      AND:   return a & b;
      OR:    return a | b;
      XOR:   return a ^ b;
      SLL:   return a << b[SHW-1:0];
      SRL:   return a >> b[SHW-1:0];
      SRA:   return word_t'($signed(a) >>> b[SHW-1:0]);
      SLT:   return ($signed(a) < $signed(b)) ? word_t'(1) : '0;
      SLTU:  return (a < b) ? word_t'(1) : '0;
      MUL:   return uprod[XLEN-1:0];
      MULH:  return sprod[2*XLEN-1:XLEN];
      MULHU: return uprod[2*XLEN-1:XLEN];
      DIV:
      begin
        if (b == '0)
          return '1;
        if (a == min_int && b == '1)
          return a;
        return word_t'($signed(a) / $signed(b));
      end
      DIVU:  return (b == '0) ? '1 : a / b;
      REM:
      begin
        if (b == '0)
          return a;
        if (a == min_int && b == '1)
          return '0;
        return word_t'($signed(a) % $signed(b));
      end
      REMU:  return (b == '0) ? a : a % b;
      default: return '0;
    endcase
  endfunction

  // Corner values mixed with random ones
  function automatic word_t pick_operand();
    case ($urandom % 8)
      0: return '0;
      1: return '1;
      2: return {1'b1, {(XLEN-1){1'b0}}};
      3: return word_t'(1);
      default: return $urandom;
    endcase
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_result(input string name, input word_t exp, input word_t act);
    if (act !== exp)
      fail_now($sformatf("Error at %0t: %s expected %h, got %h", $time, name, exp, act));
  endtask

  task automatic check_insn(input string name, input ex_insn_t exp, input ex_insn_t act);
    string got;
    if (act !== exp)
    begin
      got = $sformatf("bubble %b op %0d rd %0d", act.bubble, act.op, act.rd);
      fail_now($sformatf("Error at %0t: %s expected bubble %b op %0d rd %0d, got %s",
                         $time, name, exp.bubble, exp.op, exp.rd, got));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_now($sformatf("Error at %0t: %s expected %b, got %b", $time, name, exp, act));
  endtask

  // Retire edge pops the oldest expectation
  always @(posedge clk)
  begin : retire_check
    exp_t head;
    if (rst_n && !ex_insn.bubble && !ex_stall)
    begin
      if (exp_q.size() == 0)
        fail_now($sformatf("Error at %0t: a result retired with nothing outstanding", $time));
      else
      begin
        head = exp_q.pop_front();
        check_result("ex_r_o", head.r, ex_r);
        check_insn("ex_insn_o", head.insn, ex_insn);
      end
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
      fail_now("Timeout: the operations did not all retire within the cycle limit");
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Drives ID inputs and returns the decoded op and its expected result
  task automatic offer_op(input logic byp_ok, input word_t byp_val,
                          output ex_insn_t insn, output word_t exp_r);
    word_t a, b;
    insn.bubble = ($urandom % 10) == 0;
    insn.rd     = 5'($urandom);
    if (insn.bubble)
      insn.op = NOP;
    else if (($urandom % 3) == 0)
      insn.op = ex_op_e'(5'(11 + $urandom % 7));
    else
      insn.op = ex_op_e'(5'(1 + $urandom % 10));
    id_opa  = pick_operand();
    id_opb  = pick_operand();
    rf_v1   = $urandom;
    rf_v2   = $urandom;
    userf_a = ($urandom % 3) == 0;
    userf_b = ($urandom % 3) == 0;
    byp_a   = byp_ok && (($urandom % 3) == 0);
    byp_b   = byp_ok && (($urandom % 3) == 0);
    // Force zero divisor or MIN / -1 now and then
    if ((insn.op inside {DIV, DIVU, REM, REMU}) && (($urandom % 4) == 0))
    begin
      {userf_a, userf_b, byp_a, byp_b} = 4'b0000;
      id_opb = '0;
      if (($urandom % 2) == 0)
      begin
        id_opa = {1'b1, {(XLEN-1){1'b0}}};
        id_opb = '1;
      end
    end
    // Own result first, then register file, then decode value
    a = byp_a ? byp_val : (userf_a ? rf_v1 : id_opa);
    b = byp_b ? byp_val : (userf_b ? rf_v2 : id_opb);
    id_insn = insn;
    exp_r   = ref_exec(insn.op, a, b);
  endtask

  initial
  begin : stimulus
    ex_insn_t insn;
    exp_t     item;
    word_t    exp_r, byp_val;
    logic     byp_ok, md_prev, kill_md, accepted;
    int       hold, flush_at, n;

    void'($urandom(32'h3161));
    rst_n     = 1'b0;
    mem_stall = 1'b0;
    flush     = 1'b0;
    id_insn   = '{bubble: 1'b1, op: NOP, rd: 5'd0};
    {id_opa, id_opb, rf_v1, rf_v2} = '0;
    {userf_a, userf_b, byp_a, byp_b} = 4'b0000;
    byp_ok  = 1'b0;
    byp_val = '0;
    md_prev = 1'b0;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // State right after reset
    insn = '{bubble: 1'b1, op: NOP, rd: 5'd0};
    check_insn("ex_insn_o", insn, ex_insn);
    check_flag("ex_stall_o", 1'b0, ex_stall);
    check_result("ex_r_o", '0, ex_r);

    for (n = 0; n < NUM_OPS; n++)
    begin
      // Maybe abort the MUL/DIV in flight
      kill_md  = md_prev && (($urandom % 5) == 0);
      flush_at = 1 + ($urandom % 8);
      offer_op(byp_ok && !kill_md, byp_val, insn, exp_r);
      hold     = 0;
      accepted = 1'b0;
      // Held until accepted
      while (!accepted)
      begin
        mem_stall = ($urandom % 6) == 0;
        if (kill_md && hold == flush_at)
        begin
          flush     = 1'b1;
          mem_stall = 1'b0;
          void'(exp_q.pop_back());
        end
        @(posedge clk);
        accepted = !ex_stall && !flush;
        @(negedge clk);
        flush = 1'b0;
        hold++;
      end
      md_prev = !insn.bubble && (insn.op inside {MUL, MULH, MULHU, DIV, DIVU, REM, REMU});
      byp_ok  = !insn.bubble;
      byp_val = exp_r;
      if (!insn.bubble)
      begin
        item.insn = insn;
        item.r    = exp_r;
        exp_q.push_back(item);
      end
    end

    // Drain with bubbles
    id_insn   = '{bubble: 1'b1, op: NOP, rd: 5'd0};
    {byp_a, byp_b} = 2'b00;
    mem_stall = 1'b0;
    while (exp_q.size() != 0)
      @(negedge clk);
    @(negedge clk);

    if (ex_insn.bubble && !ex_stall)
    begin
      $display("Everything OK");
      $finish;
    end
    else
      fail_now("The DUT still shows a result or a stall after the last retirement");
  end

endmodule

// ==== files.f ====
ex_pkg.sv
ex_alu.sv
ex_muldiv.sv
ex_stage.sv
ex_stage_props.sv
tb_ex_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_ex_stage -f files.f \
  && ./obj_dir/Vtb_ex_stage > sim.log 2>&1
cat sim.log 2>/dev/null

# Pass only when the log holds the pass line
grep -qs "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
